// File: hdl/scan_params.svh
`ifndef SCAN_PARAMS_SVH
`define SCAN_PARAMS_SVH

// Number of interleaved flows tracked by each matcher
`define SCAN_NUM_STREAMS 64

// Stream id width, enough for every flow
`define SCAN_SID_W 6

// Width of every packet and alert counter
`define SCAN_COUNT_W 16

// Pattern length in bytes
`define SCAN_PAT_LEN 4

// Automaton state holds 0 to SCAN_PAT_LEN matched bytes
`define SCAN_STATE_W 3

// Fixed pattern strings, first byte in the top byte lane
// Neither has a prefix that is also a suffix
`define SCAN_PATTERN_A "evil"
`define SCAN_PATTERN_B "worm"

`endif

// File: hdl/scan_pkg.sv
`include "scan_params.svh"

package scan_pkg;

  // One input beat, one character or control event per cycle
  typedef struct packed {
    logic                   start;
    logic [`SCAN_SID_W-1:0] stream_id;
    // Restore zero state instead of the saved one
    logic                   new_stream;
    logic                   char_vld;
    logic [7:0]             char;
    logic                   eop;
  } scan_beat_t;

  // End of packet result from one matcher
  typedef struct packed {
    logic                   done;
    logic [`SCAN_SID_W-1:0] stream_id;
    // Only meaningful when enabled is set
    logic                   hit;
    logic                   enabled;
  } match_result_t;

  // Merged verdict for one packet
  typedef struct packed {
    logic                   valid;
    logic [`SCAN_SID_W-1:0] stream_id;
    logic                   hit_a;
    logic                   hit_b;
    // Both patterns seen in this packet
    logic                   alert;
  } scan_verdict_t;

endpackage

// File: hdl/string_dfa.sv
`timescale 1ns/1ps

`include "scan_params.svh"

module string_dfa #(
  parameter logic [8*`SCAN_PAT_LEN-1:0] PATTERN = `SCAN_PATTERN_A
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [7:0]               char,
  input  logic                     char_vld,
  input  logic [`SCAN_STATE_W-1:0] state_in,
  input  logic                     state_load,
  output logic [`SCAN_STATE_W-1:0] state,
  output logic                     accept
);

  localparam int LEN = `SCAN_PAT_LEN;
  // Last byte index, reaching it completes the match
  localparam logic [`SCAN_STATE_W-1:0] LAST = `SCAN_STATE_W'(LEN - 1);

  logic [`SCAN_STATE_W-1:0] next_state;
  logic                     next_accept;

  // Byte idx of the pattern, byte 0 sits in the top lane
  function automatic logic [7:0] pat_byte(input int idx);
    return PATTERN[8*(LEN-1-idx) +: 8];
  endfunction

  always_comb
  begin
    next_state  = state;
    next_accept = 1'b0;
    // Restored context wins over any character
    if (state_load)
    begin
      next_state = state_in;
    end
    else if (char_vld)
    begin
      if (state < LEN && char == pat_byte(int'(state)))
      begin
        if (state == LAST)
        begin
          // Full match, report and start over from empty
          next_state  = '0;
          next_accept = 1'b1;
        end
        else
        begin
          next_state = state + 1'b1;
        end
      end
      // Mismatch may still begin a new attempt
      else if (char == pat_byte(0))
        next_state = `SCAN_STATE_W'(1);
      else
        next_state = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state  <= '0;
      accept <= 1'b0;
    end
    else
    begin
      state  <= next_state;
      accept <= next_accept;
    end
  end

  // Matched byte count stays within the pattern
  a_state_range: assert property (@(posedge clk) disable iff (!rst_n) state <= LEN);

endmodule

// File: hdl/stream_context_matcher.sv
`timescale 1ns/1ps

`include "scan_params.svh"

module stream_context_matcher
  import scan_pkg::*;
#(
  parameter logic [8*`SCAN_PAT_LEN-1:0] PATTERN = `SCAN_PATTERN_A
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  scan_beat_t               beat,
  input  logic                     enable,
  output match_result_t            result,
  output logic [`SCAN_COUNT_W-1:0] count
);

  // Saved automaton state per flow
  // Contents are only trusted after a new_stream packet of that flow
  logic [`SCAN_STATE_W-1:0] state_mem [`SCAN_NUM_STREAMS];

  // Registered beat feeding the automaton
  scan_beat_t beat_r;

  // Restore stage
  logic                     load_r;
  logic [`SCAN_STATE_W-1:0] state_in_r;

  // Automaton outputs and their registered copies
  logic [`SCAN_STATE_W-1:0] dfa_state;
  logic                     dfa_accept;
  logic [`SCAN_STATE_W-1:0] state_out_r;
  logic                     accept_r;

  // Sticky hit for the current packet
  logic hit_flag;
  // Accept still in flight when eop closely follows the last char
  logic hit_now;

  assign hit_now = hit_flag | accept_r;

  // Input register, control bits cleared by reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      beat_r.start    <= 1'b0;
      beat_r.char_vld <= 1'b0;
      beat_r.eop      <= 1'b0;
    end
    else
    begin
      beat_r.start    <= beat.start;
      beat_r.char_vld <= beat.char_vld;
      beat_r.eop      <= beat.eop;
    end
  end

  // Payload fields of the input register
  always_ff @(posedge clk)
  begin
    beat_r.stream_id  <= beat.stream_id;
    beat_r.new_stream <= beat.new_stream;
    beat_r.char       <= beat.char;
  end

  // Restore one cycle after start, zero for a fresh flow
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      load_r <= 1'b0;
    else
      load_r <= beat_r.start;
  end

  always_ff @(posedge clk)
  begin
    if (beat_r.new_stream)
      state_in_r <= '0;
    else
      state_in_r <= state_mem[beat_r.stream_id];
  end

  string_dfa #(
    .PATTERN (PATTERN)
  ) u_dfa (
    .clk        (clk),
    .rst_n      (rst_n),
    .char       (beat_r.char),
    .char_vld   (beat_r.char_vld),
    .state_in   (state_in_r),
    .state_load (load_r),
    .state      (dfa_state),
    .accept     (dfa_accept)
  );

  // Output register around the automaton
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out_r <= '0;
      accept_r    <= 1'b0;
    end
    else
    begin
      state_out_r <= dfa_state;
      accept_r    <= dfa_accept;
    end
  end

  // Save context at eop, only for an enabled engine
  always_ff @(posedge clk)
  begin
    if (beat.eop && enable)
      state_mem[beat.stream_id] <= state_out_r;
  end

  // Hit flag, count and end of packet result
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      hit_flag <= 1'b0;
      count    <= '0;
      result   <= '0;
    end
    else
    begin
      if (beat_r.start)
        hit_flag <= 1'b0;
      else if (accept_r)
        hit_flag <= 1'b1;

      result.done <= beat.eop;
      if (beat.eop)
      begin
        result.stream_id <= beat.stream_id;
        result.hit       <= enable & hit_now;
        result.enabled   <= enable;
        if (enable)
          count <= count + `SCAN_COUNT_W'(hit_now);
      end
    end
  end

  // Beat kinds never share a cycle
  a_beat_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({beat.start, beat.char_vld, beat.eop}));

endmodule

// File: hdl/match_combiner.sv
`timescale 1ns/1ps

`include "scan_params.svh"

module match_combiner
  import scan_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  match_result_t            result_a,
  input  match_result_t            result_b,
  output scan_verdict_t            verdict,
  output logic [`SCAN_COUNT_W-1:0] alert_count
);

  // Qualified hits, a disabled engine never reports
  logic hit_a_w;
  logic hit_b_w;
  logic alert_w;

  assign hit_a_w = result_a.enabled & result_a.hit;
  assign hit_b_w = result_b.enabled & result_b.hit;
  assign alert_w = result_a.done & hit_a_w & hit_b_w;

  // Both matchers run in lockstep, so one done drives the verdict
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      verdict     <= '0;
      alert_count <= '0;
    end
    else
    begin
      verdict.valid <= result_a.done;
      if (result_a.done)
      begin
        verdict.stream_id <= result_a.stream_id;
        verdict.hit_a     <= hit_a_w;
        verdict.hit_b     <= hit_b_w;
        verdict.alert     <= alert_w;
      end
      else
      begin
        verdict.alert <= 1'b0;
      end

      // Alert total moves with the verdict
      if (alert_w)
        alert_count <= alert_count + 1'b1;
    end
  end

  // Matchers see the same beats, results must line up
  a_done_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (result_a.done == result_b.done) &&
    (!result_a.done || result_a.stream_id == result_b.stream_id));

endmodule

// File: hdl/pattern_scan_top.sv
`timescale 1ns/1ps

`include "scan_params.svh"

module pattern_scan_top
  import scan_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  scan_beat_t               beat,
  input  logic                     enable_a,
  input  logic                     enable_b,
  output scan_verdict_t            verdict,
  output logic [`SCAN_COUNT_W-1:0] count_a,
  output logic [`SCAN_COUNT_W-1:0] count_b,
  output logic [`SCAN_COUNT_W-1:0] alert_count
);

  match_result_t result_a;
  match_result_t result_b;

  // Engine A watches for the first pattern
  stream_context_matcher #(
    .PATTERN (`SCAN_PATTERN_A)
  ) u_match_a (
    .clk    (clk),
    .rst_n  (rst_n),
    .beat   (beat),
    .enable (enable_a),
    .result (result_a),
    .count  (count_a)
  );

  // Engine B sees the same beats
  stream_context_matcher #(
    .PATTERN (`SCAN_PATTERN_B)
  ) u_match_b (
    .clk    (clk),
    .rst_n  (rst_n),
    .beat   (beat),
    .enable (enable_b),
    .result (result_b),
    .count  (count_b)
  );

  // One verdict per packet
  match_combiner u_combiner (
    .clk         (clk),
    .rst_n       (rst_n),
    .result_a    (result_a),
    .result_b    (result_b),
    .verdict     (verdict),
    .alert_count (alert_count)
  );

endmodule

// File: tests/pattern_scan_tb.sv
`timescale 1ns/1ps

`include "scan_params.svh"

module pattern_scan_tb
  import scan_pkg::*;
();

  localparam logic [8*`SCAN_PAT_LEN-1:0] PAT_A = `SCAN_PATTERN_A;
  localparam logic [8*`SCAN_PAT_LEN-1:0] PAT_B = `SCAN_PATTERN_B;
  // Cycles allowed between eop and its verdict before giving up
  localparam int VERDICT_TIMEOUT = 20;

  // Expected verdict and counter values for one packet
  typedef struct {
    logic [`SCAN_SID_W-1:0] sid;
    logic                   hit_a;
    logic                   hit_b;
    logic                   alert;
    int                     count_a;
    int                     count_b;
    int                     alerts;
    int                     eop_cycle;
  } expect_t;

  logic                     clk;
  logic                     rst_n;
  scan_beat_t               beat;
  logic                     enable_a;
  logic                     enable_b;
  scan_verdict_t            verdict;
  logic [`SCAN_COUNT_W-1:0] count_a;
  logic [`SCAN_COUNT_W-1:0] count_b;
  logic [`SCAN_COUNT_W-1:0] alert_count;

  // Reference state per engine and per flow
  logic [`SCAN_STATE_W-1:0] model_state [2][`SCAN_NUM_STREAMS];
  int                       model_count [2];
  int                       model_alerts;
  logic                     last_hit [2];
  bit                       seen [`SCAN_NUM_STREAMS];

  expect_t     exp_q [$];
  logic [7:0]  pkt_chars [$];
  logic [31:0] lcg_state = 32'd79083;
  int          cycle_cnt = 0;
  // Cursor that walks through pattern bytes across packets
  int          cur_pat = 0;
  int          cur_idx = 0;
  int          flow_ids [4] = '{10, 21, 42, 63};

  pattern_scan_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat        (beat),
    .enable_a    (enable_a),
    .enable_b    (enable_b),
    .verdict     (verdict),
    .count_a     (count_a),
    .count_b     (count_b),
    .alert_count (alert_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "Stopping after the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
      stop_on_failure();
    end
  endtask

  // LCG draw in 0 .. range-1
  function automatic int lcg(input int range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'((lcg_state >> 16) % 32'(range));
  endfunction

  // Mostly pattern bytes in order, sometimes a random letter
  function automatic logic [7:0] rand_char();
    logic [8*`SCAN_PAT_LEN-1:0] pat;
    logic [7:0]                 ch;
    if (lcg(8) < 2)
      return 8'h61 + 8'(lcg(26));
    pat = (cur_pat != 0) ? PAT_B : PAT_A;
    ch  = pat[8*(`SCAN_PAT_LEN-1-cur_idx) +: 8];
    cur_idx++;
    if (cur_idx == `SCAN_PAT_LEN)
    begin
      cur_idx = 0;
      cur_pat = lcg(2);
    end
    return ch;
  endfunction

  // One character through the matching rule, returns accept and next matched length
  function automatic logic [`SCAN_STATE_W:0] ref_step(input logic [8*`SCAN_PAT_LEN-1:0] pat,
      input logic [`SCAN_STATE_W-1:0] st, input logic [7:0] ch);
    int         idx;
    logic [7:0] want;
    idx  = int'(st);
    want = pat[8*(`SCAN_PAT_LEN-1-idx) +: 8];
    if (ch == want && idx == `SCAN_PAT_LEN-1)
      return {1'b1, `SCAN_STATE_W'(0)};
    else if (ch == want)
      return {1'b0, `SCAN_STATE_W'(idx + 1)};
    else if (ch == pat[8*`SCAN_PAT_LEN-1 -: 8])
      return {1'b0, `SCAN_STATE_W'(1)};
    return '0;
  endfunction

  // Advance one cycle, control bits drop unless set again
  task automatic next_beat();
    @(posedge clk);
    #2;
    beat.start    = 1'b0;
    beat.char_vld = 1'b0;
    beat.eop      = 1'b0;
  endtask

  // Model then drive the packet held in pkt_chars
  task automatic send_packet(input logic [`SCAN_SID_W-1:0] sid, input logic ns,
                             input logic en_a, input logic en_b);
    expect_t                  exp;
    logic [`SCAN_STATE_W:0]   step;
    logic [`SCAN_STATE_W-1:0] st;
    logic                     en;
    for (int e = 0; e < 2; e++)
    begin
      en = (e == 0) ? en_a : en_b;
      st = ns ? '0 : model_state[e][sid];
      last_hit[e] = 1'b0;
      foreach (pkt_chars[i])
      begin
        step = ref_step((e == 0) ? PAT_A : PAT_B, st, pkt_chars[i]);
        st   = step[`SCAN_STATE_W-1:0];
        if (step[`SCAN_STATE_W])
          last_hit[e] = 1'b1;
      end
      // Disabled engine keeps its saved state and count
      last_hit[e] = last_hit[e] & en;
      if (en)
      begin
        model_state[e][sid] = st;
        model_count[e] += int'(last_hit[e]);
      end
    end
    if (last_hit[0] && last_hit[1])
      model_alerts++;
    // Flow state is known once both engines have saved it
    if (en_a && en_b)
      seen[sid] = 1'b1;
    exp.sid     = sid;
    exp.hit_a   = last_hit[0];
    exp.hit_b   = last_hit[1];
    exp.alert   = last_hit[0] & last_hit[1];
    exp.count_a = model_count[0];
    exp.count_b = model_count[1];
    exp.alerts  = model_alerts;
    next_beat();
    beat.start      = 1'b1;
    beat.stream_id  = sid;
    beat.new_stream = ns;
    enable_a        = en_a;
    enable_b        = en_b;
    // First character two cycles after start
    next_beat();
    foreach (pkt_chars[i])
    begin
      next_beat();
      beat.char_vld = 1'b1;
      beat.char     = pkt_chars[i];
    end
    // eop three cycles after the last character
    repeat (3) next_beat();
    beat.eop      = 1'b1;
    exp.eop_cycle = cycle_cnt;
    exp_q.push_back(exp);
    repeat (2) next_beat();
  endtask

  task automatic send_text(input logic [`SCAN_SID_W-1:0] sid, input logic ns, input string s,
                           input logic en_a, input logic en_b);
    pkt_chars.delete();
    for (int i = 0; i < s.len(); i++)
      pkt_chars.push_back(s[i]);
    send_packet(sid, ns, en_a, en_b);
  endtask

  // Directed scenario sanity on the model side, the DUT is compared by the checker
  task automatic expect_hits(input logic a, input logic b);
    check_value("model hit_a", last_hit[0], a);
    check_value("model hit_b", last_hit[1], b);
  endtask

  // Compare each verdict and the counters against the queued expectations
  initial
  begin : compare_verdicts
    expect_t exp;
    forever
    begin
      @(negedge clk);
      if (verdict.valid === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Verdict at %0t ns with no packet outstanding", $time);
          stop_on_failure();
        end
        else
        begin
          exp = exp_q.pop_front();
          check_value("verdict latency", cycle_cnt - exp.eop_cycle, 2);
          check_value("verdict.stream_id", verdict.stream_id, exp.sid);
          check_value("verdict.hit_a", verdict.hit_a, exp.hit_a);
          check_value("verdict.hit_b", verdict.hit_b, exp.hit_b);
          check_value("verdict.alert", verdict.alert, exp.alert);
          check_value("count_a", count_a, exp.count_a);
          check_value("count_b", count_b, exp.count_b);
          check_value("alert_count", alert_count, exp.alerts);
        end
      end
      else if (exp_q.size() != 0 && cycle_cnt - exp_q[0].eop_cycle > VERDICT_TIMEOUT)
      begin
        $display("Timeout: no verdict for the packet on stream %0d", exp_q[0].sid);
        stop_on_failure();
      end
    end
  end

  initial
  begin
    logic [`SCAN_SID_W-1:0] sid;
    logic                   ns;
    int                     len;
    int                     wait_cnt;
    beat           = '0;
    enable_a       = 1'b0;
    enable_b       = 1'b0;
    rst_n          = 1'b0;
    model_count[0] = 0;
    model_count[1] = 0;
    model_alerts   = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (4) next_beat();

    // Whole patterns inside one packet
    send_text(1, 1, "xevilx", 1, 1);
    expect_hits(1, 0);
    send_text(2, 1, "aworm", 1, 1);
    expect_hits(0, 1);
    // Split over two packets with another flow in between
    send_text(3, 1, "abev", 1, 1);
    expect_hits(0, 0);
    send_text(4, 1, "wormq", 1, 1);
    send_text(3, 0, "ilq", 1, 1);
    expect_hits(1, 0);
    // Fresh flow drops the saved head of B
    send_text(3, 0, "xxwo", 1, 1);
    send_text(3, 1, "rmxx", 1, 1);
    expect_hits(0, 0);
    // Engine A off for a packet that holds its pattern
    // Its saved "ev" must survive for the next packet
    send_text(6, 1, "qqev", 1, 1);
    send_text(6, 0, "xevilx", 0, 1);
    expect_hits(0, 0);
    send_text(6, 0, "ilz", 1, 1);
    expect_hits(1, 0);
    // Both patterns in one packet
    send_text(7, 1, "evilworm", 1, 1);
    expect_hits(1, 1);

    // Random traffic over four interleaved flows
    for (int p = 0; p < 200; p++)
    begin
      sid = `SCAN_SID_W'(flow_ids[lcg(4)]);
      ns  = !seen[sid] || lcg(12) == 0;
      len = 3 + lcg(10);
      pkt_chars.delete();
      repeat (len) pkt_chars.push_back(rand_char());
      send_packet(sid, ns, lcg(4) != 0, lcg(4) != 0);
      repeat (lcg(3)) next_beat();
    end

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 100)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    @(negedge clk);
    if (exp_q.size() != 0)
    begin
      $display("Timeout: %0d verdicts still missing at the end", exp_q.size());
      stop_on_failure();
    end
    else
    begin
      check_value("final count_a", count_a, model_count[0]);
      check_value("final count_b", count_b, model_count[1]);
      check_value("final alert_count", alert_count, model_alerts);
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+hdl
hdl/scan_pkg.sv
hdl/string_dfa.sv
hdl/stream_context_matcher.sv
hdl/match_combiner.sv
hdl/pattern_scan_top.sv
tests/pattern_scan_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator, run the testbench, then search the log for a failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module pattern_scan_tb -o pattern_scan_sim > "$LOG" 2>&1 \
  && ./obj_dir/pattern_scan_sim >> "$LOG" 2>&1 \
  || echo "Simulation build or run returned an error" >> "$LOG"
cat "$LOG"
grep -q "Result: FAILED" "$LOG" && exit 1
grep -q "Result: PASSED" "$LOG" || exit 1
exit 0
